/* Makefile */
# Verilator build and run of the memory fabric testbench

TOP       ?= tb_soc_bus
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
FILELIST  ?= build.f
VERILATOR ?= verilator

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: TOP BUILD_DIR LOG FILELIST VERILATOR"

test:
	@mkdir -p $(BUILD_DIR)
	$(VERILATOR) --binary --assert --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG) && echo "Result: pass" || (echo "Result: fail"; exit 1)

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
src/mem_map_pkg.sv
src/bus_pkg.sv
src/bus_decoder.sv
src/boot_rom.sv
src/scrambled_ram.sv
src/mmio_timer.sv
src/sys_ctrl.sv
src/soc_bus_top.sv
testbench/soc_bus_props.sv
testbench/tb_soc_bus.sv

/* src/boot_rom.sv */
/*
 * Boot ROM with words generated from their index
 * Combinational read, writes ignored
 */
`timescale 1ns/1ps

module boot_rom (
  input  logic               cs,
  input  bus_pkg::core_req_t req,
  output bus_pkg::core_rsp_t rsp
);

  logic [mem_map_pkg::rom_addr_bits-1:0] index;

  // Only the low bits address the ROM
  assign index = req.addr[mem_map_pkg::rom_addr_bits-1:0];

  // Tag in both upper bytes, then complement and index
  always_comb begin
    rsp.rdata = {mem_map_pkg::rom_tag, mem_map_pkg::rom_tag, ~index, index};
    rsp.ready = cs;
  end

  // There is no storage, so req.we and req.wdata have no effect

endmodule

/* src/bus_decoder.sv */
/*
 * Bus decoder between the master and the four cores
 * Area and MMIO core decode with one chip select per core
 * Registered read data and ready, RAM scrambling, trap injection
 */
`timescale 1ns/1ps

module bus_decoder (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  bus_pkg::cpu_req_t                     req,
  input  logic                                  force_trap,
  input  logic [31:0]                           ram_scramble,
  input  logic [mem_map_pkg::ram_addr_bits-1:0] ram_aslr,
  output logic [31:0]                           rdata,
  output logic                                  ready,

  output logic                                  rom_cs,
  output bus_pkg::core_req_t                    rom_req,
  input  bus_pkg::core_rsp_t                    rom_rsp,

  output logic                                  ram_cs,
  output bus_pkg::core_req_t                    ram_req,
  input  bus_pkg::core_rsp_t                    ram_rsp,

  output logic                                  timer_cs,
  output bus_pkg::core_req_t                    timer_req,
  input  bus_pkg::core_rsp_t                    timer_rsp,

  output logic                                  sys_cs,
  output bus_pkg::core_req_t                    sys_req,
  input  bus_pkg::core_rsp_t                    sys_rsp
);

  logic [31:0]        rdata_reg;
  logic [31:0]        rdata_new;
  logic               ready_reg;
  logic               ready_new;
  logic               start;
  logic [31:0]        ram_mask;
  bus_pkg::core_req_t mmio_req;

  // ------------------------------------------------------------------------
  // Core requests
  // ------------------------------------------------------------------------
  assign start = req.valid && !ready_reg;

  // Data mask depends on the key and on the address itself
  assign ram_mask = ram_scramble ^ {2{req.addr[15:0]}};

  assign mmio_req.we    = req.wstrb;
  assign mmio_req.addr  = {{(mem_map_pkg::ram_addr_bits - mem_map_pkg::reg_addr_bits){1'b0}},
                           req.addr[mem_map_pkg::word_lsb +: mem_map_pkg::reg_addr_bits]};
  assign mmio_req.wdata = req.wdata;

  assign timer_req = mmio_req;
  assign sys_req   = mmio_req;

  assign rom_req.we    = req.wstrb;
  assign rom_req.addr  = {{(mem_map_pkg::ram_addr_bits - mem_map_pkg::rom_addr_bits){1'b0}},
                          req.addr[mem_map_pkg::word_lsb +: mem_map_pkg::rom_addr_bits]};
  assign rom_req.wdata = req.wdata;

  // Scrambled word address and data
  assign ram_req.we    = req.wstrb;
  assign ram_req.addr  = req.addr[mem_map_pkg::word_lsb +: mem_map_pkg::ram_addr_bits] ^ ram_aslr;
  assign ram_req.wdata = req.wdata ^ ram_mask;

  // ------------------------------------------------------------------------
  // Decode and response mux
  // ------------------------------------------------------------------------
  always_comb begin
    mem_map_pkg::area_e area;
    mem_map_pkg::core_e core;

    area = mem_map_pkg::area_e'(req.addr[mem_map_pkg::area_msb:mem_map_pkg::area_lsb]);
    core = mem_map_pkg::core_e'(req.addr[mem_map_pkg::core_msb:mem_map_pkg::core_lsb]);

    rdata_new = 32'h0;
    ready_new = 1'b0;
    rom_cs    = 1'b0;
    ram_cs    = 1'b0;
    timer_cs  = 1'b0;
    sys_cs    = 1'b0;

    if (start) begin
      if (force_trap) begin
        // Protected fetch gets the trap word, no core sees it
        rdata_new = mem_map_pkg::illegal_instr;
        ready_new = 1'b1;
      end else begin
        case (area)
          mem_map_pkg::rom_area: begin
            rom_cs    = 1'b1;
            rdata_new = rom_rsp.rdata;
            ready_new = rom_rsp.ready;
          end
          mem_map_pkg::ram_area: begin
            ram_cs    = 1'b1;
            rdata_new = ram_rsp.rdata ^ ram_mask;
            ready_new = ram_rsp.ready;
          end
          mem_map_pkg::mmio_area: begin
            case (core)
              mem_map_pkg::timer_core: begin
                timer_cs  = 1'b1;
                rdata_new = timer_rsp.rdata;
                ready_new = timer_rsp.ready;
              end
              mem_map_pkg::sys_ctrl_core: begin
                sys_cs    = 1'b1;
                rdata_new = sys_rsp.rdata;
                ready_new = sys_rsp.ready;
              end
              default: begin
                ready_new = 1'b1;
              end
            endcase
          end
          // Reserved area answers zero
          default: begin
            ready_new = 1'b1;
          end
        endcase
      end
    end
  end

  // Response register, one cycle after the access starts
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rdata_reg <= 32'h0;
      ready_reg <= 1'b0;
    end else begin
      rdata_reg <= rdata_new;
      ready_reg <= ready_new;
    end
  end

  assign rdata = rdata_reg;
  assign ready = ready_reg;

endmodule

/* src/bus_pkg.sv */
/*
 * Bus structures
 * Master request, per-core request and per-core response
 */
package bus_pkg;

  // Request from the bus master, one outstanding at a time
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } cpu_req_t;

  // Request to one core, qualified by its own cs wire
  typedef struct packed {
    logic [3:0]                               we;
    logic [mem_map_pkg::ram_addr_bits-1:0]    addr;
    logic [31:0]                              wdata;
  } core_req_t;

  // Combinational answer of one core
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } core_rsp_t;

  // Register index and word index share the addr field,
  // narrower indices sit in its low bits

endpackage

/* src/mem_map_pkg.sv */
/*
 * Address map of the memory fabric
 * Area and MMIO core prefix enums, address field positions
 * Memory sizes, register indices and fixed values
 */
package mem_map_pkg;

  // ------------------------------------------------------------------------
  // Address fields
  // ------------------------------------------------------------------------
  localparam int unsigned area_msb = 31;
  localparam int unsigned area_lsb = 30;
  localparam int unsigned core_msb = 29;
  localparam int unsigned core_lsb = 24;
  localparam int unsigned word_lsb = 2;

  // Top two address bits
  typedef enum logic [1:0] {
    rom_area      = 2'd0,
    ram_area      = 2'd1,
    reserved_area = 2'd2,
    mmio_area     = 2'd3
  } area_e;

  // MMIO core prefix, any other value is unmapped
  typedef enum logic [5:0] {
    timer_core    = 6'h01,
    sys_ctrl_core = 6'h3f
  } core_e;

  // ------------------------------------------------------------------------
  // Sizes and fixed values
  // ------------------------------------------------------------------------
  localparam int unsigned rom_addr_bits = 8;
  localparam int unsigned ram_addr_bits = 10;
  localparam int unsigned reg_addr_bits = 8;

  localparam logic [31:0] illegal_instr  = 32'h0000_0000;
  localparam logic [7:0]  rom_tag        = 8'hb0;
  localparam logic [31:0] sys_name_value = 32'h5343_5431;

  // System-control registers
  localparam logic [reg_addr_bits-1:0] sys_mode_reg     = 8'd0;
  localparam logic [reg_addr_bits-1:0] sys_scramble_reg = 8'd1;
  localparam logic [reg_addr_bits-1:0] sys_aslr_reg     = 8'd2;
  localparam logic [reg_addr_bits-1:0] sys_name_reg     = 8'd3;

  // Timer registers and control bits
  localparam logic [reg_addr_bits-1:0] tmr_ctrl_reg     = 8'd0;
  localparam logic [reg_addr_bits-1:0] tmr_status_reg   = 8'd1;
  localparam logic [reg_addr_bits-1:0] tmr_prescale_reg = 8'd2;
  localparam logic [reg_addr_bits-1:0] tmr_value_reg    = 8'd3;
  localparam int unsigned tmr_start_bit = 0;
  localparam int unsigned tmr_stop_bit  = 1;

endpackage

/* src/mmio_timer.sv */
/*
 * Countdown timer on the MMIO bus
 * Prescaler, start and stop control, running status
 */
`timescale 1ns/1ps

module mmio_timer (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cs,
  input  bus_pkg::core_req_t req,
  output bus_pkg::core_rsp_t rsp
);

  typedef enum logic {
    tmr_idle,
    tmr_running
  } run_e;

  run_e        state;
  logic [31:0] prescale;
  logic [31:0] value;
  logic [31:0] tick_cnt;
  logic        wr;
  logic [mem_map_pkg::reg_addr_bits-1:0] idx;

  assign wr  = cs && (|req.we);
  assign idx = req.addr[mem_map_pkg::reg_addr_bits-1:0];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state    <= tmr_idle;
      prescale <= 32'h0;
      value    <= 32'h0;
      tick_cnt <= 32'h0;
    end else begin
      // Count down once every prescale+1 cycles
      if (state == tmr_running) begin
        if (value == 32'h0) begin
          state <= tmr_idle;
        end else if (tick_cnt == prescale) begin
          tick_cnt <= 32'h0;
          value    <= value - 32'h1;
          if (value == 32'h1) begin
            state <= tmr_idle;
          end
        end else begin
          tick_cnt <= tick_cnt + 32'h1;
        end
      end

      // Bus writes override the counting in the same cycle
      if (wr) begin
        case (idx)
          mem_map_pkg::tmr_ctrl_reg: begin
            if (req.wdata[mem_map_pkg::tmr_stop_bit]) begin
              state <= tmr_idle;
            end else if (req.wdata[mem_map_pkg::tmr_start_bit]) begin
              state    <= tmr_running;
              tick_cnt <= 32'h0;
            end
          end
          mem_map_pkg::tmr_prescale_reg: prescale <= req.wdata;
          mem_map_pkg::tmr_value_reg:    value    <= req.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (idx)
      mem_map_pkg::tmr_status_reg:   rsp.rdata = {31'h0, state == tmr_running};
      mem_map_pkg::tmr_prescale_reg: rsp.rdata = prescale;
      mem_map_pkg::tmr_value_reg:    rsp.rdata = value;
      default:                       rsp.rdata = 32'h0;
    endcase
    rsp.ready = cs;
  end

endmodule

/* src/scrambled_ram.sv */
/*
 * Word RAM behind the scrambler
 * Byte strobed synchronous write, combinational read
 */
`timescale 1ns/1ps

module scrambled_ram (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cs,
  input  bus_pkg::core_req_t req,
  output bus_pkg::core_rsp_t rsp
);

  localparam int unsigned ram_words = 2 ** mem_map_pkg::ram_addr_bits;

  logic [31:0] mem [0:ram_words-1];
  logic        write_en;

  // No writes while the fabric is held in reset
  assign write_en = reset_n && cs && (|req.we);

  // ------------------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (write_en) begin
      for (int b = 0; b < 4; b++) begin
        if (req.we[b]) begin
          mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------------------
  always_comb begin
    rsp.rdata = mem[req.addr];
    rsp.ready = cs;
  end

endmodule

/* src/soc_bus_top.sv */
/*
 * Top level of the memory fabric
 * Bus decoder with boot ROM, scrambled RAM, timer and system control
 */
`timescale 1ns/1ps

module soc_bus_top (
  input  logic              clk,
  input  logic              reset_n,
  input  bus_pkg::cpu_req_t req,
  output logic [31:0]       rdata,
  output logic              ready
);

  logic               rom_cs;
  bus_pkg::core_req_t rom_req;
  bus_pkg::core_rsp_t rom_rsp;

  logic               ram_cs;
  bus_pkg::core_req_t ram_req;
  bus_pkg::core_rsp_t ram_rsp;

  logic               timer_cs;
  bus_pkg::core_req_t timer_req;
  bus_pkg::core_rsp_t timer_rsp;

  logic               sys_cs;
  bus_pkg::core_req_t sys_req;
  bus_pkg::core_rsp_t sys_rsp;

  // Security controls from system control
  logic [31:0]                           ram_scramble;
  logic [mem_map_pkg::ram_addr_bits-1:0] ram_aslr;
  logic                                  force_trap;

  bus_decoder u_decoder (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (req),
    .force_trap   (force_trap),
    .ram_scramble (ram_scramble),
    .ram_aslr     (ram_aslr),
    .rdata        (rdata),
    .ready        (ready),
    .rom_cs       (rom_cs),
    .rom_req      (rom_req),
    .rom_rsp      (rom_rsp),
    .ram_cs       (ram_cs),
    .ram_req      (ram_req),
    .ram_rsp      (ram_rsp),
    .timer_cs     (timer_cs),
    .timer_req    (timer_req),
    .timer_rsp    (timer_rsp),
    .sys_cs       (sys_cs),
    .sys_req      (sys_req),
    .sys_rsp      (sys_rsp)
  );

  boot_rom u_rom (.cs(rom_cs), .req(rom_req), .rsp(rom_rsp));

  scrambled_ram u_ram (
    .clk     (clk),
    .reset_n (reset_n),
    .cs      (ram_cs),
    .req     (ram_req),
    .rsp     (ram_rsp)
  );

  mmio_timer u_timer (
    .clk     (clk),
    .reset_n (reset_n),
    .cs      (timer_cs),
    .req     (timer_req),
    .rsp     (timer_rsp)
  );

  sys_ctrl u_sys_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (sys_cs),
    .req          (sys_req),
    .rsp          (sys_rsp),
    .cpu_req      (req),
    .ram_scramble (ram_scramble),
    .ram_aslr     (ram_aslr),
    .force_trap   (force_trap)
  );

endmodule

/* src/sys_ctrl.sv */
/*
 * System-control core
 * Firmware/application mode, RAM scramble keys, fetch protection
 */
`timescale 1ns/1ps

module sys_ctrl (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  cs,
  input  bus_pkg::core_req_t                    req,
  output bus_pkg::core_rsp_t                    rsp,
  input  bus_pkg::cpu_req_t                     cpu_req,
  output logic [31:0]                           ram_scramble,
  output logic [mem_map_pkg::ram_addr_bits-1:0] ram_aslr,
  output logic                                  force_trap
);

  typedef enum logic {
    fw_mode,
    app_mode
  } mode_e;

  mode_e       mode;
  logic [31:0] scramble_key;
  logic [mem_map_pkg::ram_addr_bits-1:0] aslr_key;
  logic        wr;
  logic        rom_fetch;
  logic [mem_map_pkg::reg_addr_bits-1:0] idx;

  assign wr  = cs && (|req.we);
  assign idx = req.addr[mem_map_pkg::reg_addr_bits-1:0];

  // ------------------------------------------------------------------------
  // Mode and keys
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mode         <= fw_mode;
      scramble_key <= 32'h0;
      aslr_key     <= '0;
    end else if (wr) begin
      // Application mode is sticky until reset
      if (idx == mem_map_pkg::sys_mode_reg && req.wdata[0]) begin
        mode <= app_mode;
      end
      // Keys are locked once the application runs
      if (mode == fw_mode) begin
        if (idx == mem_map_pkg::sys_scramble_reg) begin
          scramble_key <= req.wdata;
        end
        if (idx == mem_map_pkg::sys_aslr_reg) begin
          aslr_key <= req.wdata[mem_map_pkg::ram_addr_bits-1:0];
        end
      end
    end
  end

  assign ram_scramble = scramble_key;
  assign ram_aslr     = aslr_key;

  // Application code may not execute from the boot ROM
  assign rom_fetch = cpu_req.valid && cpu_req.instr &&
                     (cpu_req.addr[mem_map_pkg::area_msb:mem_map_pkg::area_lsb] ==
                      mem_map_pkg::rom_area);
  assign force_trap = (mode == app_mode) && rom_fetch;

  // ------------------------------------------------------------------------
  // Register read
  // ------------------------------------------------------------------------
  always_comb begin
    case (idx)
      mem_map_pkg::sys_mode_reg:     rsp.rdata = {31'h0, mode == app_mode};
      mem_map_pkg::sys_scramble_reg: rsp.rdata = scramble_key;
      mem_map_pkg::sys_aslr_reg:     rsp.rdata = {{(32 - mem_map_pkg::ram_addr_bits){1'b0}},
                                                  aslr_key};
      mem_map_pkg::sys_name_reg:     rsp.rdata = mem_map_pkg::sys_name_value;
      default:                       rsp.rdata = 32'h0;
    endcase
    rsp.ready = cs;
  end

endmodule

/* testbench/soc_bus_props.sv */
/*
 * Concurrent assertions on the bus decoder
 * Ready pulse width, chip select exclusion, trap and reset behavior
 */
`timescale 1ns/1ps

module soc_bus_props (
  input logic clk,
  input logic reset_n,
  input logic ready,
  input logic force_trap,
  input logic rom_cs,
  input logic ram_cs,
  input logic timer_cs,
  input logic sys_cs
);

  logic [3:0] cs_all;

  assign cs_all = {rom_cs, ram_cs, timer_cs, sys_cs};

  ready_one_cycle: assert property (@(posedge clk) disable iff (!reset_n) ready |=> !ready)
    else $error("ready stayed high for two cycles");

  cs_exclusive: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(cs_all))
    else $error("more than one chip select is high");

  // Trapped fetch must not reach any core
  no_cs_on_trap: assert property (@(posedge clk) disable iff (!reset_n)
                                  force_trap |-> (cs_all == 4'b0000))
    else $error("chip select high while force_trap is set");

  ready_low_in_reset: assert property (@(posedge clk) !reset_n |=> !ready)
    else $error("ready high during reset");

endmodule

bind bus_decoder soc_bus_props decoder_props (
  .clk        (clk),
  .reset_n    (reset_n),
  .ready      (ready),
  .force_trap (force_trap),
  .rom_cs     (rom_cs),
  .ram_cs     (ram_cs),
  .timer_cs   (timer_cs),
  .sys_cs     (sys_cs)
);

/* testbench/tb_soc_bus.sv */
/*
 * Testbench for the memory fabric top level
 * Bus-master tasks, reference model, compare task, watchdog and tests
 */
`timescale 1ns/1ps

module tb_soc_bus;

  localparam int n_rom_reads  = 16;
  localparam int n_ram_words  = 24;
  localparam int timer_budget = 1200;
  // Rough count of bus transactions over all tests
  localparam int n_transactions = n_rom_reads + 5 * n_ram_words + 40;
  localparam int timeout_cycles = n_transactions * 10 + timer_budget + 100;

  localparam logic [31:0] key_one  = 32'h9e37_79b9;
  localparam logic [31:0] key_two  = 32'h6a09_e667;
  localparam logic [9:0]  aslr_key = 10'h2a5;

  // Countdown used for the run-to-zero test
  localparam int tmr_count    = 5;
  localparam int tmr_prescale = 2;

  logic              clk;
  logic              reset_n;
  bus_pkg::cpu_req_t req;
  logic [31:0]       rdata;
  logic              ready;

  integer      seed = 32'h73e9_afb7;
  int          cycle_count;
  logic [31:0] shadow [0:1023];
  int unsigned ram_idx [n_ram_words];

  soc_bus_top DUT (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (req),
    .rdata   (rdata),
    .ready   (ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset_n) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

  // --------------------------------------------------------------------------
  // Reference model and address helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] rom_word(input int unsigned index);
    logic [7:0] low;
    low = index[7:0];
    return {8'hb0, 8'hb0, ~low, low};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [31:0] rom_addr(input int unsigned index);
    return index << 2;
  endfunction

  function automatic logic [31:0] ram_addr(input int unsigned index);
    return 32'h4000_0000 | (index << 2);
  endfunction

  function automatic logic [31:0] mmio_addr(input logic [5:0] core, input logic [7:0] index);
    return {2'b11, core, 14'h0, index, 2'b00};
  endfunction

  // --------------------------------------------------------------------------
  // Checks and bus master
  // --------------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  // One request with ready expected one cycle after valid
  task automatic drive_request(input logic instr, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] wstrb,
                               output logic [31:0] data);
    bus_pkg::cpu_req_t next_req;
    int                cycles;
    next_req.valid = 1'b1;
    next_req.instr = instr;
    next_req.addr  = addr;
    next_req.wdata = wdata;
    next_req.wstrb = wstrb;
    cycles = 0;
    @(posedge clk);
    req <= next_req;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end while (!ready && cycles < 8);
    if (!ready) begin
      abort_run($sformatf("No ready within %0d cycles for address %h", cycles, addr));
    end
    if (cycles != 1) begin
      abort_run($sformatf("Ready came %0d cycles after valid instead of 1", cycles));
    end
    data = rdata;
    @(posedge clk);
    req.valid <= 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    logic [31:0] ignored;
    drive_request(1'b0, addr, wdata, wstrb, ignored);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic instr,
                          output logic [31:0] data);
    drive_request(instr, addr, 32'h0, 4'h0, data);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] data;
    logic [31:0] r;
    logic [31:0] frozen;
    logic [3:0]  strb;
    logic [7:0]  rom_idx;
    int          t_start;
    int          bound;

    req     <= '0;
    reset_n <= 1'b0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;

    // Boot ROM contents and an ignored write
    for (int i = 0; i < n_rom_reads; i++) begin
      r = $random(seed);
      rom_idx = r[7:0];
      bus_read(rom_addr({24'h0, rom_idx}), 1'b0, data);
      check_value("rom rdata", rom_word({24'h0, rom_idx}), data);
    end
    bus_write(rom_addr(5), 32'hdead_beef, 4'hf);
    bus_read(rom_addr(5), 1'b0, data);
    check_value("rom rdata after write", rom_word(5), data);

    // RAM traffic after the keys are set in firmware mode
    bus_write(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_scramble_reg),
              key_one, 4'hf);
    bus_write(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_aslr_reg),
              {22'h0, aslr_key}, 4'hf);
    for (int i = 0; i < n_ram_words; i++) begin
      r = $random(seed);
      ram_idx[i] = {22'h0, r[9:0]};
      r = $random(seed);
      bus_write(ram_addr(ram_idx[i]), r, 4'hf);
      shadow[ram_idx[i]] = r;
    end
    for (int i = 0; i < n_ram_words; i++) begin
      r = $random(seed);
      strb = r[3:0];
      if (strb == 4'h0) begin
        strb = 4'h8;
      end
      r = $random(seed);
      bus_write(ram_addr(ram_idx[i]), r, strb);
      shadow[ram_idx[i]] = merge_bytes(shadow[ram_idx[i]], r, strb);
    end
    for (int i = 0; i < n_ram_words; i++) begin
      bus_read(ram_addr(ram_idx[i]), 1'b0, data);
      check_value("ram rdata", shadow[ram_idx[i]], data);
    end

    // New scramble key leaves the old mask in stored words
    bus_write(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_scramble_reg),
              key_two, 4'hf);
    for (int i = 0; i < n_ram_words; i++) begin
      bus_read(ram_addr(ram_idx[i]), 1'b0, data);
      check_value("ram rdata rekeyed", shadow[ram_idx[i]] ^ key_one ^ key_two, data);
    end
    bus_read(32'h8000_0040, 1'b0, data);
    check_value("reserved rdata", 32'h0, data);
    bus_read(32'hc200_0008, 1'b0, data);
    check_value("unmapped mmio rdata", 32'h0, data);
    bus_write(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_scramble_reg),
              key_one, 4'hf);

    // Firmware mode allows ROM fetches
    bus_read(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_mode_reg), 1'b0, data);
    check_value("mode before switch", 32'h0, data);
    bus_read(rom_addr(7), 1'b1, data);
    check_value("rom fetch in fw mode", rom_word(7), data);

    // Application mode locks keys and traps ROM fetches
    bus_write(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_mode_reg), 32'h1, 4'hf);
    bus_read(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_mode_reg), 1'b0, data);
    check_value("mode after switch", 32'h1, data);
    bus_write(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_scramble_reg),
              key_two, 4'hf);
    bus_write(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_aslr_reg), 32'h0, 4'hf);
    bus_read(mmio_addr(mem_map_pkg::sys_ctrl_core, mem_map_pkg::sys_scramble_reg), 1'b0, data);
    check_value("locked scramble key", key_one, data);
    for (int i = 0; i < n_ram_words; i++) begin
      bus_read(ram_addr(ram_idx[i]), 1'b0, data);
      check_value("ram rdata in app mode", shadow[ram_idx[i]], data);
    end
    bus_read(rom_addr(7), 1'b1, data);
    check_value("rom fetch in app mode", 32'h0, data);
    bus_read(rom_addr(7), 1'b0, data);
    check_value("rom data read in app mode", rom_word(7), data);

    // Timer runs down to zero within value * (prescale + 1) cycles
    bus_write(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_prescale_reg),
              tmr_prescale, 4'hf);
    bus_write(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_value_reg),
              tmr_count, 4'hf);
    bus_write(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_ctrl_reg), 32'h1, 4'hf);
    t_start = cycle_count;
    bound = tmr_count * (tmr_prescale + 1) + 16;
    bus_read(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_status_reg), 1'b0, data);
    check_value("timer status after start", 32'h1, data);
    do begin
      bus_read(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_status_reg), 1'b0, data);
      if (cycle_count - t_start > bound) begin
        abort_run("Timer still running after its countdown time");
      end
    end while (data[0] == 1'b1);
    check_value("timer status at end", 32'h0, data);
    bus_read(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_value_reg), 1'b0, data);
    check_value("timer value at end", 32'h0, data);

    // Stop freezes the count
    bus_write(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_prescale_reg), 32'd3, 4'hf);
    bus_write(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_value_reg), 32'd200, 4'hf);
    bus_write(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_ctrl_reg), 32'h1, 4'hf);
    repeat (10) @(posedge clk);
    bus_write(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_ctrl_reg), 32'h2, 4'hf);
    bus_read(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_value_reg), 1'b0, frozen);
    if (frozen == 32'h0) begin
      abort_run("Timer reached zero before the stop took effect");
    end
    repeat (20) @(posedge clk);
    bus_read(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_value_reg), 1'b0, data);
    check_value("timer value after stop", frozen, data);
    bus_read(mmio_addr(mem_map_pkg::timer_core, mem_map_pkg::tmr_status_reg), 1'b0, data);
    check_value("timer status after stop", 32'h0, data);

    $display("TESTS PASSED");
    $finish;
  end

endmodule
